// ==== design/csr_consts.svh ====
// machine CSR widths, mstatus and mie/mip bit positions, misa value, mtvec reset and mode codes

`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

// datapath widths
`define CSR_XLEN            32                      // register and address width
`define CSR_IDX_W           12                      // csr index field of the instruction
`define CSR_CAUSE_W         4                       // exception code bits kept in mcause

// mstatus fields
`define CSR_MIE_BIT         3                       // global machine interrupt enable
`define CSR_MPIE_BIT        7                       // enable saved at trap entry
`define CSR_MPP_LSB         11                      // previous privilege, two bits wide
`define CSR_MPP_W           2
`define CSR_MPP_MACHINE     2'b11                   // only machine mode exists

// mie and mip share one layout
`define CSR_MSIE_BIT        3                       // software interrupt enable/pending
`define CSR_MEIE_BIT        11                      // external interrupt enable/pending

// mcause layout
`define CSR_MCAUSE_INT_BIT  31                      // set when the trap was an interrupt

// misa: mxl=1 (32 bit) in [31:30], extension I in bit 8
`define CSR_MISA_VALUE      32'h4000_0100

// mtvec
`define CSR_RESET_MTVEC     32'h0000_0100           // handler base out of reset, direct mode
`define CSR_MTVEC_DIRECT    2'b00                   // every trap jumps to base
`define CSR_MTVEC_VECTORED  2'b01                   // interrupts jump to base + 4*cause

// load and store size codes, low two bits of funct3
`define CSR_SIZE_BYTE       2'b00
`define CSR_SIZE_HALF       2'b01
`define CSR_SIZE_WORD       2'b10

// Instruction alignment is not checked here. Only data accesses
// raise a misaligned trap, and they use the size codes above.

`endif

// ==== design/csr_pkg.sv ====
// csr op, csr address and trap cause enums, request, exception, trap event and state structs

`include "csr_consts.svh"

package csr_pkg;

    // funct3 of a system instruction
    typedef enum logic [2:0] {
        CSR_NONE = 3'b000,                          // ecall/ebreak/mret, no csr access
        CSRRW    = 3'b001,                          // read-write from rs1
        CSRRS    = 3'b010,                          // read-set from rs1
        CSRRC    = 3'b011,                          // read-clear from rs1
        CSRRWI   = 3'b101,                          // immediate variants
        CSRRSI   = 3'b110,
        CSRRCI   = 3'b111
    } csr_op_e;

    // implemented machine csr indices
    typedef enum logic [`CSR_IDX_W-1:0] {
        CSR_MSTATUS  = 12'h300,
        CSR_MISA     = 12'h301,                     // read only
        CSR_MIE      = 12'h304,
        CSR_MTVEC    = 12'h305,
        CSR_MSCRATCH = 12'h340,
        CSR_MEPC     = 12'h341,
        CSR_MCAUSE   = 12'h342,
        CSR_MTVAL    = 12'h343,
        CSR_MIP      = 12'h344                      // hardware driven, writes ignored
    } csr_addr_e;

    // exception codes; interrupt codes 3 and 11 reuse values, the intr bit tells them apart
    typedef enum logic [`CSR_CAUSE_W-1:0] {
        CAUSE_NONE        = 4'd0,                   // idle value, no trap
        CAUSE_ILLEGAL     = 4'd2,
        CAUSE_BREAK_MSI   = 4'd3,                   // ebreak, or software interrupt
        CAUSE_LOAD_MISAL  = 4'd4,
        CAUSE_STORE_MISAL = 4'd6,
        CAUSE_ECALL_MEI   = 4'd11                   // ecall from m-mode, or external interrupt
    } cause_e;

    typedef struct packed {
        logic                  stage;               // csr stage strobe
        logic                  system;              // system opcode
        csr_op_e               op;                  // funct3
        logic [`CSR_IDX_W-1:0] index;               // csr address
        logic [`CSR_XLEN-1:0]  rs1;
        logic [`CSR_XLEN-1:0]  imm;                 // zero-extended uimm
    } csr_req_t;

    typedef struct packed {
        logic                 illegal;
        logic                 ecall;
        logic                 ebreak;
        logic                 mret;
        logic                 load;                 // load opcode
        logic                 store;                // store opcode
        logic [`CSR_XLEN-1:0] alu_sum;              // effective address
    } exc_req_t;

    typedef struct packed {
        logic                 take;                 // trap entered this cycle
        logic                 ret;                  // mret this cycle
        logic                 intr;
        cause_e               cause;
        logic [`CSR_XLEN-1:0] pc;
        logic                 fault_addr_valid;     // misaligned load or store
        logic [`CSR_XLEN-1:0] fault_addr;
    } trap_evt_t;

    typedef struct packed {
        logic                 mie_global;           // mstatus.MIE
        logic                 msie;
        logic                 meie;
        logic                 msip;
        logic                 meip;
        logic [`CSR_XLEN-1:0] mtvec;
        logic [`CSR_XLEN-1:0] mepc;
    } csr_state_t;

endpackage

// ==== design/csr_trap_ctrl.sv ====
// trap controller: misaligned access check, interrupt gating, cause priority, registered trap outputs

`include "csr_consts.svh"

module csr_trap_ctrl import csr_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  csr_req_t             req,
    input  exc_req_t             exc,
    input  logic [`CSR_XLEN-1:0] pc,
    input  csr_state_t           state,
    output trap_evt_t            evt,
    output logic                 go_to_trap_q,
    output logic                 return_from_trap_q,
    output logic [`CSR_XLEN-1:0] return_address,
    output logic [`CSR_XLEN-1:0] trap_address
);

    logic       addr_misal;                         // address fails the size rule
    logic       load_misal;
    logic       store_misal;
    logic       ext_pend;                           // enabled and pending external irq
    logic       sw_pend;
    logic       is_intr;
    logic       is_exc;
    logic [1:0] mtvec_mode;
    logic [`CSR_XLEN-1:0] mtvec_base;
    logic [`CSR_XLEN-1:0] vec_offset;               // 4 * cause for vectored interrupts

    // access size comes from funct3 of the load/store
    always_comb begin
        addr_misal = 1'b0;
        case (req.op[1:0])
            `CSR_SIZE_HALF: addr_misal = exc.alu_sum[0];
            `CSR_SIZE_WORD: addr_misal = |exc.alu_sum[1:0];
            default:        addr_misal = 1'b0;      // byte access is always aligned
        endcase
    end

    assign load_misal  = exc.load & addr_misal;
    assign store_misal = exc.store & addr_misal;

    // an interrupt needs global enable, its own enable and its pending bit
    assign ext_pend = state.mie_global & state.meie & state.meip;
    assign sw_pend  = state.mie_global & state.msie & state.msip;

    assign is_intr = ext_pend | sw_pend;
    assign is_exc  = exc.illegal | exc.ecall | exc.ebreak | load_misal | store_misal;

    // event to the register file, only in a stage cycle
    always_comb begin
        evt                  = '0;
        evt.pc               = pc;
        evt.fault_addr       = exc.alu_sum;
        evt.take             = req.stage & (is_intr | is_exc);
        evt.ret              = req.stage & exc.mret & ~(is_intr | is_exc); // a trap preempts mret
        evt.intr             = is_intr;
        if (ext_pend) begin
            evt.cause = CAUSE_ECALL_MEI;            // external interrupt wins
        end else if (sw_pend) begin
            evt.cause = CAUSE_BREAK_MSI;
        end else if (exc.illegal) begin
            evt.cause = CAUSE_ILLEGAL;
        end else if (exc.ecall) begin
            evt.cause = CAUSE_ECALL_MEI;
        end else if (exc.ebreak) begin
            evt.cause = CAUSE_BREAK_MSI;
        end else if (load_misal) begin
            evt.cause = CAUSE_LOAD_MISAL;
        end else if (store_misal) begin
            evt.cause = CAUSE_STORE_MISAL;
        end else begin
            evt.cause = CAUSE_NONE;
        end
        // mtval only for the misaligned causes, not when an irq or higher exception wins
        evt.fault_addr_valid = evt.take & ~is_intr &
                               ((evt.cause == CAUSE_LOAD_MISAL) |
                                (evt.cause == CAUSE_STORE_MISAL));
    end

    assign mtvec_mode = state.mtvec[1:0];
    assign mtvec_base = {state.mtvec[`CSR_XLEN-1:2], 2'b00};
    assign vec_offset = {{(`CSR_XLEN-`CSR_CAUSE_W-2){1'b0}}, evt.cause, 2'b00};

    // registered outputs, updated on every accepted stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            go_to_trap_q       <= 1'b0;
            return_from_trap_q <= 1'b0;
            return_address     <= '0;
            trap_address       <= '0;
        end else if (req.stage) begin
            go_to_trap_q       <= evt.take;
            return_from_trap_q <= evt.ret;
            return_address     <= state.mepc;       // mepc before this cycle's update
            if (is_intr && mtvec_mode == `CSR_MTVEC_VECTORED) begin
                trap_address <= mtvec_base + vec_offset; // cause of the trap being taken
            end else begin
                trap_address <= mtvec_base;         // direct mode, or synchronous trap
            end
        end
    end

endmodule

// ==== design/csr_regfile.sv ====
// machine csr storage, read mux, read-modify-write, trap entry and mret side effects

`include "csr_consts.svh"

module csr_regfile import csr_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  csr_req_t             req,
    input  logic                 ext_irq,
    input  logic                 sw_irq,
    input  trap_evt_t            evt,
    output csr_state_t           state,
    output logic [`CSR_XLEN-1:0] csr_out
);

    logic                   csr_en;                 // csr instruction accepted this cycle
    logic [`CSR_XLEN-1:0]   src;                    // rs1 or uimm
    logic [`CSR_XLEN-1:0]   rdata;                  // current value at req.index
    logic [`CSR_XLEN-1:0]   wdata;                  // value after the op

    // architectural state
    logic                   mstatus_mie;
    logic                   mstatus_mpie;
    logic                   mie_msie;
    logic                   mie_meie;
    logic [`CSR_XLEN-1:0]   mtvec;
    logic [`CSR_XLEN-1:0]   mscratch;
    logic [`CSR_XLEN-1:0]   mepc;
    logic                   mcause_int;
    logic [`CSR_CAUSE_W-1:0] mcause_code;
    logic [`CSR_XLEN-1:0]   mtval;
    logic                   mip_msip;               // sampled sw_irq
    logic                   mip_meip;               // sampled ext_irq

    assign csr_en = req.stage & req.system & (req.op != CSR_NONE);
    assign src    = req.op[2] ? req.imm : req.rs1;  // funct3[2] selects the immediate form

    // read mux, unused bits and unknown indices read zero
    always_comb begin
        rdata = '0;
        case (req.index)
            CSR_MSTATUS: begin
                rdata[`CSR_MIE_BIT]                  = mstatus_mie;
                rdata[`CSR_MPIE_BIT]                 = mstatus_mpie;
                rdata[`CSR_MPP_LSB +: `CSR_MPP_W]    = `CSR_MPP_MACHINE; // m-mode only
            end
            CSR_MISA: rdata = `CSR_MISA_VALUE;
            CSR_MIE: begin
                rdata[`CSR_MSIE_BIT] = mie_msie;
                rdata[`CSR_MEIE_BIT] = mie_meie;
            end
            CSR_MTVEC:    rdata = mtvec;
            CSR_MSCRATCH: rdata = mscratch;
            CSR_MEPC:     rdata = mepc;
            CSR_MCAUSE: begin
                rdata[`CSR_MCAUSE_INT_BIT]    = mcause_int;
                rdata[`CSR_CAUSE_W-1:0]       = mcause_code;
            end
            CSR_MTVAL: rdata = mtval;
            CSR_MIP: begin
                rdata[`CSR_MSIE_BIT] = mip_msip;
                rdata[`CSR_MEIE_BIT] = mip_meip;
            end
            default: rdata = '0;
        endcase
    end

    // read-modify-write
    always_comb begin
        case (req.op)
            CSRRW, CSRRWI: wdata = src;
            CSRRS, CSRRSI: wdata = rdata | src;     // set bits
            CSRRC, CSRRCI: wdata = rdata & ~src;    // clear bits
            default:       wdata = rdata;           // no csr access, keep value
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mie_msie     <= 1'b0;
            mie_meie     <= 1'b0;
            mtvec        <= `CSR_RESET_MTVEC;
            mscratch     <= '0;
            mepc         <= '0;
            mcause_int   <= 1'b0;
            mcause_code  <= '0;
            mtval        <= '0;
            mip_msip     <= 1'b0;
            mip_meip     <= 1'b0;
        end else begin
            // mstatus: a csr write beats trap entry and mret
            if (csr_en && req.index == CSR_MSTATUS) begin
                mstatus_mie  <= wdata[`CSR_MIE_BIT];
                mstatus_mpie <= wdata[`CSR_MPIE_BIT];
            end else if (evt.take) begin
                mstatus_mpie <= mstatus_mie;        // save enable, mask interrupts
                mstatus_mie  <= 1'b0;
            end else if (evt.ret) begin
                mstatus_mie  <= mstatus_mpie;
                mstatus_mpie <= 1'b1;
            end

            if (csr_en && req.index == CSR_MIE) begin
                mie_msie <= wdata[`CSR_MSIE_BIT];
                mie_meie <= wdata[`CSR_MEIE_BIT];
            end

            if (csr_en && req.index == CSR_MTVEC) begin
                mtvec <= wdata;
            end

            if (csr_en && req.index == CSR_MSCRATCH) begin
                mscratch <= wdata;
            end

            // trap entry overrides software writes of mepc, mcause and mtval
            if (evt.take) begin
                mepc <= evt.pc;
            end else if (csr_en && req.index == CSR_MEPC) begin
                mepc <= {wdata[`CSR_XLEN-1:2], 2'b00}; // instructions are word aligned
            end

            if (evt.take) begin
                mcause_int  <= evt.intr;
                mcause_code <= evt.cause;
            end else if (csr_en && req.index == CSR_MCAUSE) begin
                mcause_int  <= wdata[`CSR_MCAUSE_INT_BIT];
                mcause_code <= wdata[`CSR_CAUSE_W-1:0];
            end

            if (evt.take && evt.fault_addr_valid) begin
                mtval <= evt.fault_addr;            // faulting data address
            end else if (csr_en && req.index == CSR_MTVAL) begin
                mtval <= wdata;
            end

            mip_msip <= sw_irq;                     // pending bits follow the lines
            mip_meip <= ext_irq;
        end
    end

    // read result, holds until the next csr instruction
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            csr_out <= '0;
        end else if (csr_en) begin
            csr_out <= rdata;                       // old value of the csr
        end
    end

    // view of the registers used by the trap controller
    assign state.mie_global = mstatus_mie;
    assign state.msie       = mie_msie;
    assign state.meie       = mie_meie;
    assign state.msip       = mip_msip;
    assign state.meip       = mip_meip;
    assign state.mtvec      = mtvec;
    assign state.mepc       = mepc;

endmodule

// ==== design/csr_unit.sv ====
// csr unit top: trap controller and machine csr register file

`include "csr_consts.svh"

module csr_unit import csr_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  csr_req_t             req,               // instruction view of the csr stage
    input  exc_req_t             exc,               // exception flags and address
    input  logic [`CSR_XLEN-1:0] pc,
    input  logic                 ext_irq,
    input  logic                 sw_irq,
    output logic [`CSR_XLEN-1:0] csr_out,           // old csr value to the register file
    output logic [`CSR_XLEN-1:0] return_address,    // mepc for mret
    output logic [`CSR_XLEN-1:0] trap_address,      // handler entry
    output logic                 go_to_trap_q,
    output logic                 return_from_trap_q
);

    trap_evt_t  evt;                                // trap/mret event to the regfile
    csr_state_t state;                              // enables, pending, mtvec, mepc

    csr_trap_ctrl u_trap_ctrl (
        .clk                (clk),
        .rst_n              (rst_n),
        .req                (req),
        .exc                (exc),
        .pc                 (pc),
        .state              (state),
        .evt                (evt),
        .go_to_trap_q       (go_to_trap_q),
        .return_from_trap_q (return_from_trap_q),
        .return_address     (return_address),
        .trap_address       (trap_address)
    );

    csr_regfile u_regfile (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (req),
        .ext_irq (ext_irq),
        .sw_irq  (sw_irq),
        .evt     (evt),
        .state   (state),
        .csr_out (csr_out)
    );

endmodule

// ==== verif/csr_assert.sv ====
// bound checks on csr_unit: trap flags after reset, flag exclusivity, csr_out update rule

`include "csr_consts.svh"

module csr_assert import csr_pkg::*; (
    input logic                 clk,
    input logic                 rst_n,
    input csr_req_t             req,
    input trap_evt_t            evt,
    input logic                 go_to_trap_q,
    input logic                 return_from_trap_q,
    input logic [`CSR_XLEN-1:0] csr_out
);

    int unsigned n_fail = 0;                        // failed assertion count
    logic        csr_acc;                           // accepted csr instruction

    assign csr_acc = req.stage && req.system && (req.op != CSR_NONE);

    a_reset_flags: assert property (@(posedge clk)
        $rose(rst_n) |-> !go_to_trap_q && !return_from_trap_q)
        else begin n_fail++; $error("trap flags high right after reset"); end

    a_flags_excl: assert property (@(posedge clk) disable iff (!rst_n)
        req.stage && !evt.take |=> !(go_to_trap_q && return_from_trap_q))
        else begin n_fail++; $error("trap and return flags high together"); end

    a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !csr_acc |=> $stable(csr_out))
        else begin n_fail++; $error("csr_out changed without a csr instruction"); end

endmodule

bind csr_unit csr_assert u_csr_assert (
    .clk                (clk),
    .rst_n              (rst_n),
    .req                (req),
    .evt                (evt),
    .go_to_trap_q       (go_to_trap_q),
    .return_from_trap_q (return_from_trap_q),
    .csr_out            (csr_out)
);

// ==== verif/csr_tb.sv ====
// csr_unit testbench: clock, reset, seeded random stimulus, reference model, checks, watchdog

`include "csr_consts.svh"

module csr_tb import csr_pkg::*; ();

    localparam int N_CSR   = 150;                   // csr write + read pairs
    localparam int N_SYNC  = 60;
    localparam int N_MIS   = 100;
    localparam int N_IRQ   = 40;
    localparam int N_RET   = 30;
    localparam int N_APPLY = 2*N_CSR + 5*N_SYNC + 2*N_MIS + 2 + 5*N_IRQ + 6*N_RET;
    localparam int TIMEOUT = (2*N_APPLY + 5 + 100) * 10; // two cycles per apply, plus margin

    logic        clk, rst_n, ext_irq, sw_irq;
    csr_req_t    req;
    exc_req_t    exc;
    logic [31:0] pc, csr_out, return_address, trap_address;
    logic        go_to_trap_q, return_from_trap_q;

    logic        m_mie, m_mpie, m_msie, m_meie, m_msip, m_meip; // model state
    logic [31:0] m_mtvec, m_mscratch, m_mepc, m_mcause, m_mtval;
    logic [31:0] exp_out, exp_raddr, exp_taddr;
    logic        exp_go, exp_ret, irq_e, irq_s;  // irq_e/irq_s: line levels to drive
    int          n_checks = 0, n_errors = 0, err_mark = 0;
    logic [31:0] rnd;
    logic [11:0] idx;
    csr_op_e     op;
    csr_req_t    r;
    exc_req_t    e;

    csr_unit dut (.*);

    function automatic logic [31:0] model_read(input logic [11:0] a);
        logic [31:0] v;
        v = '0;
        case (a)
            CSR_MSTATUS: begin
                v[`CSR_MIE_BIT]      = m_mie;
                v[`CSR_MPIE_BIT]     = m_mpie;
                v[`CSR_MPP_LSB +: 2] = 2'b11;       // machine mode only
            end
            CSR_MISA:     v = `CSR_MISA_VALUE;
            CSR_MIE:      v = {20'd0, m_meie, 7'd0, m_msie, 3'd0};
            CSR_MTVEC:    v = m_mtvec;
            CSR_MSCRATCH: v = m_mscratch;
            CSR_MEPC:     v = m_mepc;
            CSR_MCAUSE:   v = m_mcause;
            CSR_MTVAL:    v = m_mtval;
            CSR_MIP:      v = {20'd0, m_meip, 7'd0, m_msip, 3'd0};
            default:      v = '0;                   // unknown index
        endcase
        return v;
    endfunction

    // one clock cycle of the reference: expected outputs, then next state
    task automatic model_step(input csr_req_t q, input exc_req_t x, input logic [31:0] p);
        logic        wr, bad, lmis, smis, ext_p, sw_p, intr, any, take, ret;
        logic [3:0]  cause;
        logic [31:0] old, src, nv, base;
        wr    = q.stage && q.system && (q.op != CSR_NONE);
        old   = model_read(q.index);
        src   = (q.op inside {CSRRWI, CSRRSI, CSRRCI}) ? q.imm : q.rs1;
        nv    = (q.op inside {CSRRS, CSRRSI}) ? (old | src) :
                (q.op inside {CSRRC, CSRRCI}) ? (old & ~src) : src;
        bad   = (q.op[1:0] == 2'b01 && x.alu_sum[0]) ||
                (q.op[1:0] == 2'b10 && x.alu_sum[1:0] != 2'b00); // half / word size rule
        lmis  = x.load && bad;
        smis  = x.store && bad;
        ext_p = m_mie && m_meie && m_meip;
        sw_p  = m_mie && m_msie && m_msip;
        intr  = ext_p || sw_p;
        any   = intr || x.illegal || x.ecall || x.ebreak || lmis || smis;
        take  = q.stage && any;
        ret   = q.stage && x.mret && !any;
        cause = ext_p ? 4'd11 : sw_p ? 4'd3 : x.illegal ? 4'd2 : x.ecall ? 4'd11 :
                x.ebreak ? 4'd3 : lmis ? 4'd4 : smis ? 4'd6 : 4'd0;
        base  = {m_mtvec[31:2], 2'b00};
        if (q.stage) begin
            exp_go    = take;
            exp_ret   = ret;
            exp_raddr = m_mepc;                     // value before this cycle
            exp_taddr = (intr && m_mtvec[1:0] == 2'b01) ? base + {26'd0, cause, 2'b00} : base;
        end
        if (wr) exp_out = old;
        if (wr && q.index == CSR_MSTATUS) begin
            m_mie  = nv[`CSR_MIE_BIT];
            m_mpie = nv[`CSR_MPIE_BIT];
        end else if (take) begin
            m_mpie = m_mie;
            m_mie  = 1'b0;
        end else if (ret) begin
            m_mie  = m_mpie;
            m_mpie = 1'b1;
        end
        if (wr && q.index == CSR_MIE) {m_meie, m_msie} = {nv[`CSR_MEIE_BIT], nv[`CSR_MSIE_BIT]};
        if (wr && q.index == CSR_MTVEC) m_mtvec = nv;
        if (wr && q.index == CSR_MSCRATCH) m_mscratch = nv;
        if (take) m_mepc = p;
        else if (wr && q.index == CSR_MEPC) m_mepc = {nv[31:2], 2'b00};
        if (take) m_mcause = {intr, 27'd0, cause};
        else if (wr && q.index == CSR_MCAUSE) m_mcause = {nv[31], 27'd0, nv[3:0]};
        if (take && !intr && (cause == 4'd4 || cause == 4'd6)) m_mtval = x.alu_sum;
        else if (wr && q.index == CSR_MTVAL) m_mtval = nv;
        m_msip = irq_s;                             // pending bits lag the lines by a cycle
        m_meip = irq_e;
    endtask

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] want);
        n_checks++;
        if (got !== want) begin
            n_errors++;
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    task automatic compare_outputs();
        check("csr_out", csr_out, exp_out);
        check("return_address", return_address, exp_raddr);
        check("trap_address", trap_address, exp_taddr);
        check("go_to_trap_q", 32'(go_to_trap_q), 32'(exp_go));
        check("return_from_trap_q", 32'(return_from_trap_q), 32'(exp_ret));
    endtask

    // stage cycle, then an idle cycle, then compare at the falling edge
    task automatic apply(input csr_req_t q, input exc_req_t x, input logic [31:0] p);
        @(posedge clk);
        req     <= q;
        exc     <= x;
        pc      <= p;
        ext_irq <= irq_e;
        sw_irq  <= irq_s;
        model_step(q, x, p);
        @(posedge clk);
        req <= '0;
        exc <= '0;
        model_step('0, '0, p);
        @(negedge clk);
        compare_outputs();
    endtask

    function automatic csr_req_t csr_instr(input csr_op_e o, input logic [11:0] a,
                                           input logic [31:0] rs1, input logic [31:0] imm);
        csr_req_t q;
        q        = '0;
        q.stage  = 1'b1;
        q.system = 1'b1;
        q.op     = o;
        q.index  = a;
        q.rs1    = rs1;
        q.imm    = imm;
        return q;
    endfunction

    task automatic read_csr(input logic [11:0] a);
        apply(csr_instr(CSRRS, a, '0, '0), '0, '0); // set with zero leaves the csr as is
    endtask

    task automatic test_done(input string name);
        $display("test %s finished, %0d errors", name, n_errors - err_mark);
        err_mark = n_errors;
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(TIMEOUT);
        $display("watchdog: stimulus did not finish within %0d time units", TIMEOUT);
        $display("Test failed");
        $finish;
    end

    initial begin
        rnd      = $urandom(32'h4695);
        rst_n   <= 1'b0;
        req     <= '0;
        exc     <= '0;
        pc      <= '0;
        ext_irq <= 1'b0;
        sw_irq  <= 1'b0;
        {m_mie, m_mpie, m_msie, m_meie, m_msip, m_meip} = '0;
        {m_mscratch, m_mepc, m_mcause, m_mtval} = '0;
        m_mtvec = `CSR_RESET_MTVEC;
        {exp_out, exp_raddr, exp_taddr, exp_go, exp_ret, irq_e, irq_s} = '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        compare_outputs();                          // reset values
        test_done("reset");
        for (int i = 0; i < N_CSR; i++) begin
            rnd = $urandom;
            idx = (rnd[1:0] == 2'd0) ? CSR_MSCRATCH : (rnd[1:0] == 2'd1) ? CSR_MTVEC : CSR_MIE;
            op  = csr_op_e'((rnd[4:2] == 3'b000 || rnd[4:2] == 3'b100) ? 3'b001 : rnd[4:2]);
            apply(csr_instr(op, idx, $urandom, $urandom), '0, '0);
            read_csr(idx);
        end
        test_done("csr read/write");
        for (int i = 0; i < N_SYNC; i++) begin
            rnd = $urandom;
            apply(csr_instr(CSRRW, CSR_MSTATUS, rnd & 32'h0000_0088, '0), '0, '0);
            r         = '0;
            r.stage   = 1'b1;
            r.system  = 1'b1;
            e         = '0;
            e.illegal = rnd[0];
            e.ecall   = rnd[1];
            e.ebreak  = rnd[2];
            apply(r, e, {rnd[31:8], 8'h40});
            read_csr(CSR_MCAUSE);                   // also shows return_address = trap pc
            read_csr(CSR_MSTATUS);
            read_csr(CSR_MEPC);
        end
        test_done("synchronous traps");
        for (int i = 0; i < N_MIS; i++) begin
            rnd       = $urandom;
            r         = '0;
            r.stage   = 1'b1;
            r.op      = csr_op_e'({1'b0, (rnd[1:0] == 2'b11) ? 2'b10 : rnd[1:0]}); // size
            e         = '0;
            e.load    = rnd[2];
            e.store   = ~rnd[2];
            e.alu_sum = $urandom;
            apply(r, e, {rnd[31:8], 8'h80});
            read_csr(CSR_MTVAL);
        end
        test_done("misaligned access");
        rnd = $urandom;
        apply(csr_instr(CSRRW, CSR_MTVEC, {rnd[31:2], 2'b01}, '0), '0, '0); // vectored
        apply(csr_instr(CSRRW, CSR_MIE, 32'h0000_0808, '0), '0, '0);
        for (int i = 0; i < N_IRQ; i++) begin
            apply(csr_instr(CSRRSI, CSR_MSTATUS, '0, 32'h8), '0, '0);
            rnd     = $urandom;
            irq_e   = rnd[0];
            irq_s   = rnd[1];
            r       = '0;
            r.stage = 1'b1;
            apply(r, '0, {rnd[31:8], 8'hc0});       // lines reach mip
            apply(r, '0, {rnd[31:8], 8'hc4});       // interrupt taken here
            irq_e   = 1'b0;
            irq_s   = 1'b0;
            read_csr(CSR_MCAUSE);
        end
        test_done("interrupts");
        for (int i = 0; i < N_RET; i++) begin
            rnd = $urandom;
            apply(csr_instr(CSRRW, CSR_MSTATUS, rnd & 32'h0000_0088, '0), '0, '0);
            r        = '0;
            r.stage  = 1'b1;
            r.system = 1'b1;
            e        = '0;
            e.mret   = 1'b1;
            apply(r, e, '0);
            read_csr(CSR_MSTATUS);
            apply(csr_instr(CSRRW, CSR_MISA, rnd, '0), '0, '0); // read only
            read_csr(CSR_MISA);
            check("misa", csr_out, `CSR_MISA_VALUE);
            idx = rnd[23:12];
            if (idx inside {CSR_MSTATUS, CSR_MISA, CSR_MIE, CSR_MTVEC, CSR_MSCRATCH,
                            CSR_MEPC, CSR_MCAUSE, CSR_MTVAL, CSR_MIP}) idx = 12'hbc0;
            read_csr(idx);
            check("unknown csr", csr_out, 32'd0);
        end
        test_done("mret, misa, unknown index");
        $display("summary: %0d checks, %0d mismatches, %0d assertion failures",
                 n_checks, n_errors, dut.u_csr_assert.n_fail);
        if (n_errors == 0 && dut.u_csr_assert.n_fail == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+design
design/csr_pkg.sv
design/csr_trap_ctrl.sv
design/csr_regfile.sv
design/csr_unit.sv
verif/csr_assert.sv
verif/csr_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the csr_unit testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module csr_tb -o csr_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/csr_sim +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Test completed successfully" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
